/* compile.f */
design/cpu_pkg.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/cpu_core_top.sv
verif/cpu_core_asserts.sv
verif/cpu_core_tb.sv

/* design/cpu_core_top.sv */
`timescale 1ns/100ps

module cpu_core_top
    import cpu_pkg::*;
(
    input  logic                  aclk,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  logic [xlen-1:0]       inst_word,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    logic [reg_addr_w-1:0] rf_raddr1;
    logic [reg_addr_w-1:0] rf_raddr2;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;
    dec_to_exe_t           dec_to_exe;
    exe_to_res_t           exe_to_res;
    rf_write_t             exe_fwd;
    rf_write_t             res_write;

    decode_stage decode_stage_inst (
        .aclk       (aclk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .exe_fwd    (exe_fwd),
        .res_write  (res_write),
        .to_exe     (dec_to_exe)
    );

    execute_stage execute_stage_inst (
        .aclk     (aclk),
        .reset    (reset),
        .from_dec (dec_to_exe),
        .exe_fwd  (exe_fwd),
        .to_res   (exe_to_res)
    );

    result_stage result_stage_inst (
        .from_exe          (exe_to_res),
        .res_write         (res_write),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // retiring write lands here one edge after the trace shows it
    regfile regfile_inst (
        .aclk   (aclk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (res_write)
    );

endmodule

/* design/cpu_pkg.sv */
package cpu_pkg;

    // datapath and register-number widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int nreg       = 32;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;
    localparam logic [xlen-1:0] pc_step  = 32'd4;

    // 3R register forms, opcode in bits 31:15
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_sltu  = 17'h00025;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // 2RI12 form, opcode in bits 31:22, si12 in 21:10
    localparam logic [9:0] op_addi_w = 10'h00a;

    // 1RI20 form, opcode in bits 31:25, si20 in 24:5
    localparam logic [6:0] op_lu12i_w = 7'h0a;

    // lui forwards src2 untouched
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_lui  = 4'd7
    } alu_op_e;

    // decode to execute stage register
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
    } dec_to_exe_t;

    // execute to result stage register
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       result;
    } exe_to_res_t;

    // one register-file write, also used as a bypass source
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } rf_write_t;

endpackage

/* design/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic                  aclk,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  logic [xlen-1:0]       inst_word,
    output logic [reg_addr_w-1:0] rf_raddr1,
    output logic [reg_addr_w-1:0] rf_raddr2,
    input  logic [xlen-1:0]       rf_rdata1,
    input  logic [xlen-1:0]       rf_rdata2,
    input  rf_write_t             exe_fwd,
    input  rf_write_t             res_write,
    output dec_to_exe_t           to_exe
);

    logic                  inst_valid_q;
    logic [xlen-1:0]       inst_q;
    logic [xlen-1:0]       inst_pc_q;
    logic [xlen-1:0]       fetch_pc;
    logic [reg_addr_w-1:0] rd;
    logic [11:0]           si12;
    logic [19:0]           si20;
    logic                  known;
    logic                  use_imm;
    alu_op_e               alu_op;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       opnd1;
    logic [xlen-1:0]       opnd2;
    dec_to_exe_t           dec_next;

    // youngest producer wins, then the retiring one, then the array
    function automatic logic [xlen-1:0] bypass(
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0]       rf_data,
        input rf_write_t             exe_w,
        input rf_write_t             res_w
    );
        if (addr == '0) begin
            return '0;
        end else if (exe_w.we && exe_w.waddr == addr) begin
            return exe_w.wdata;
        end else if (res_w.we && res_w.waddr == addr) begin
            return res_w.wdata;
        end
        return rf_data;
    endfunction

    // instruction strobe capture, pc advances per accepted word
    always_ff @(posedge aclk) begin
        if (reset) begin
            inst_valid_q <= 1'b0;
            fetch_pc     <= reset_pc;
        end else begin
            inst_valid_q <= inst_valid;
            if (inst_valid) begin
                fetch_pc <= fetch_pc + pc_step;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_valid) begin
            inst_q    <= inst_word;
            inst_pc_q <= fetch_pc;
        end
    end

    assign rd        = inst_q[4:0];
    assign rf_raddr1 = inst_q[9:5];
    assign rf_raddr2 = inst_q[14:10];
    assign si12      = inst_q[21:10];
    assign si20      = inst_q[24:5];

    always_comb begin
        known   = 1'b1;
        use_imm = 1'b0;
        alu_op  = alu_add;
        imm     = '0;
        if (inst_q[31:22] == op_addi_w) begin
            use_imm = 1'b1;
            imm     = {{(xlen-12){si12[11]}}, si12};
        end else if (inst_q[31:25] == op_lu12i_w) begin
            use_imm = 1'b1;
            alu_op  = alu_lui;
            imm     = {si20, 12'b0};
        end else begin
            case (inst_q[31:15])
                op_add_w: alu_op = alu_add;
                op_sub_w: alu_op = alu_sub;
                op_and:   alu_op = alu_and;
                op_or:    alu_op = alu_or;
                op_xor:   alu_op = alu_xor;
                op_slt:   alu_op = alu_slt;
                op_sltu:  alu_op = alu_sltu;
                // anything else retires silently
                default:  known = 1'b0;
            endcase
        end
    end

    always_comb begin
        opnd1 = bypass(rf_raddr1, rf_rdata1, exe_fwd, res_write);
        opnd2 = bypass(rf_raddr2, rf_rdata2, exe_fwd, res_write);
    end

    always_comb begin
        dec_next.valid    = inst_valid_q;
        dec_next.pc       = inst_pc_q;
        dec_next.alu_op   = alu_op;
        dec_next.src1     = opnd1;
        dec_next.src2     = use_imm ? imm : opnd2;
        dec_next.rf_we    = known && (rd != '0);
        dec_next.rf_waddr = rd;
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            to_exe.valid <= 1'b0;
        end else begin
            to_exe <= dec_next;
        end
    end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage
    import cpu_pkg::*;
(
    input  logic        aclk,
    input  logic        reset,
    input  dec_to_exe_t from_dec,
    output rf_write_t   exe_fwd,
    output exe_to_res_t to_res
);

    logic [xlen-1:0] alu_result;
    exe_to_res_t     res_next;

    always_comb begin
        case (from_dec.alu_op)
            alu_add:  alu_result = from_dec.src1 + from_dec.src2;
            alu_sub:  alu_result = from_dec.src1 - from_dec.src2;
            alu_and:  alu_result = from_dec.src1 & from_dec.src2;
            alu_or:   alu_result = from_dec.src1 | from_dec.src2;
            alu_xor:  alu_result = from_dec.src1 ^ from_dec.src2;
            alu_slt: begin
                alu_result = {{(xlen-1){1'b0}},
                              $signed(from_dec.src1) < $signed(from_dec.src2)};
            end
            alu_sltu: begin
                alu_result = {{(xlen-1){1'b0}}, from_dec.src1 < from_dec.src2};
            end
            alu_lui:  alu_result = from_dec.src2;
            default:  alu_result = '0;
        endcase
    end

    // write that this instruction will make, for decode bypass
    assign exe_fwd.we    = from_dec.valid && from_dec.rf_we;
    assign exe_fwd.waddr = from_dec.rf_waddr;
    assign exe_fwd.wdata = alu_result;

    always_comb begin
        res_next.valid    = from_dec.valid;
        res_next.pc       = from_dec.pc;
        res_next.rf_we    = from_dec.rf_we;
        res_next.rf_waddr = from_dec.rf_waddr;
        res_next.result   = alu_result;
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            to_res.valid <= 1'b0;
        end else begin
            to_res <= res_next;
        end
    end

endmodule

/* design/regfile.sv */
`timescale 1ns/100ps

module regfile
    import cpu_pkg::*;
(
    input  logic                  aclk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    input  rf_write_t             wr
);

    logic [xlen-1:0] regs [nreg];

    // r0 is never stored, reads force it to zero
    always_ff @(posedge aclk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* design/result_stage.sv */
`timescale 1ns/100ps

module result_stage
    import cpu_pkg::*;
(
    input  exe_to_res_t           from_exe,
    output rf_write_t             res_write,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    logic retire_we;

    // bubbles and non-writing words drop here
    assign retire_we = from_exe.valid && from_exe.rf_we;

    assign res_write.we    = retire_we;
    assign res_write.waddr = from_exe.rf_waddr;
    assign res_write.wdata = from_exe.result;

    // trace mirrors the register-file write, byte enables all or none
    assign debug_wb_pc       = from_exe.pc;
    assign debug_wb_rf_we    = {4{retire_we}};
    assign debug_wb_rf_wnum  = from_exe.rf_waddr;
    assign debug_wb_rf_wdata = from_exe.result;

endmodule

/* run_sim.sh */
#!/bin/sh
# build the cpu core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module cpu_core_tb -f compile.f -o cpu_core_sim || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/cpu_core_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "^TB PASSED$" && exit 0 || exit 1

/* verif/cpu_core_asserts.sv */
`timescale 1ns/100ps

// trace checks on the result-stage outputs as seen at the core top
module cpu_core_asserts
    import cpu_pkg::*;
(
    input logic                  aclk,
    input logic                  reset,
    input logic [3:0]            debug_wb_rf_we,
    input logic [reg_addr_w-1:0] debug_wb_rf_wnum
);

    // byte enables move together
    we_all_or_none: assert property (
        @(posedge aclk) disable iff (reset)
        (debug_wb_rf_we == 4'h0) || (debug_wb_rf_we == 4'hf)
    ) else $error("debug_wb_rf_we is %h, neither all zeros nor all ones", debug_wb_rf_we);

    // r0 writes are dropped in decode
    no_r0_write: assert property (
        @(posedge aclk) disable iff (reset)
        (debug_wb_rf_we != 4'h0) |-> (debug_wb_rf_wnum != '0)
    ) else $error("trace shows a write to register 0");

    // stage valids cleared after the first reset edge
    quiet_in_reset: assert property (
        @(posedge aclk)
        $past(reset) |-> (debug_wb_rf_we == 4'h0)
    ) else $error("trace write enable active during reset");

endmodule

bind cpu_core_top cpu_core_asserts cpu_core_asserts_inst (
    .aclk             (aclk),
    .reset            (reset),
    .debug_wb_rf_we   (debug_wb_rf_we),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

/* verif/cpu_core_tb.sv */
`timescale 1ns/100ps

module cpu_core_tb
    import cpu_pkg::*;
();

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 10;
    localparam int wb_latency      = 3;
    localparam int drain_limit     = 50;
    localparam int watchdog_cycles = 5000;
    // major opcode outside the supported set
    localparam logic [16:0] op_unknown = 17'h0003f;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] wnum;
        logic [xlen-1:0]       wdata;
        int                    stamp;
    } wb_entry_t;

    logic                  aclk;
    logic                  reset;
    logic                  inst_valid;
    logic [xlen-1:0]       inst_word;
    logic [xlen-1:0]       debug_wb_pc;
    logic [3:0]            debug_wb_rf_we;
    logic [reg_addr_w-1:0] debug_wb_rf_wnum;
    logic [xlen-1:0]       debug_wb_rf_wdata;

    logic [xlen-1:0] model_regs [nreg];
    logic [xlen-1:0] model_pc;
    wb_entry_t       expect_q [$];
    int              cycle_cnt = 0;
    int              seed;

    cpu_core_top cpu_core_top_inst (
        .aclk              (aclk),
        .reset             (reset),
        .inst_valid        (inst_valid),
        .inst_word         (inst_word),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #(clk_period / 2) aclk = ~aclk;
        end
    end

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] rr_word(input logic [16:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rj,
                                              input logic [11:0] si12);
        return {op_addi_w, si12, rj, rd};
    endfunction

    function automatic logic [31:0] lu12i_word(input logic [4:0] rd, input logic [19:0] si20);
        return {op_lu12i_w, si20, rd};
    endfunction

    // architectural result of one word against the model register file
    function automatic void predict_write(input logic [31:0] word, output logic we,
                                          output logic [4:0] wnum, output logic [31:0] wdata);
        logic [31:0] a;
        logic [31:0] b;
        a     = model_regs[word[9:5]];
        b     = model_regs[word[14:10]];
        we    = 1'b1;
        wnum  = word[4:0];
        wdata = '0;
        if (word[31:22] == op_addi_w) begin
            wdata = a + {{20{word[21]}}, word[21:10]};
        end else if (word[31:25] == op_lu12i_w) begin
            wdata = {word[24:5], 12'h000};
        end else begin
            case (word[31:15])
                op_add_w: wdata = a + b;
                op_sub_w: wdata = a - b;
                op_and:   wdata = a & b;
                op_or:    wdata = a | b;
                op_xor:   wdata = a ^ b;
                op_slt:   wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                op_sltu:  wdata = (a < b) ? 32'd1 : 32'd0;
                default:  we = 1'b0;
            endcase
        end
        // r0 stays zero and never shows on the trace
        if (wnum == 5'd0) begin
            we = 1'b0;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic issue_inst(input logic [31:0] word);
        logic      we;
        logic [4:0] wnum;
        logic [31:0] wdata;
        wb_entry_t e;
        @(posedge aclk);
        #1;
        inst_valid = 1'b1;
        inst_word  = word;
        predict_write(word, we, wnum, wdata);
        if (we) begin
            model_regs[wnum] = wdata;
            e.pc    = model_pc;
            e.wnum  = wnum;
            e.wdata = wdata;
            e.stamp = cycle_cnt;
            expect_q.push_back(e);
        end
        // every accepted word takes a pc slot whether it writes or not
        model_pc = model_pc + pc_step;
    endtask

    task automatic idle_cycle();
        @(posedge aclk);
        #1;
        inst_valid = 1'b0;
        inst_word  = '0;
    endtask

    // long enough gap that nothing is bypassed
    task automatic issue_alone(input logic [31:0] word);
        issue_inst(word);
        repeat (4) idle_cycle();
    endtask

    task automatic random_inst(output logic [31:0] word);
        int          r;
        int          sel;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        r   = $random(seed);
        sel = $unsigned(r) % 10;
        // registers 0 to 7 only so dependencies are dense
        rd  = {2'b00, r[10:8]};
        rj  = {2'b00, r[13:11]};
        rk  = {2'b00, r[16:14]};
        r   = $random(seed);
        case (sel)
            0:       word = rr_word(op_add_w, rd, rj, rk);
            1:       word = rr_word(op_sub_w, rd, rj, rk);
            2:       word = rr_word(op_and, rd, rj, rk);
            3:       word = rr_word(op_or, rd, rj, rk);
            4:       word = rr_word(op_xor, rd, rj, rk);
            5:       word = rr_word(op_slt, rd, rj, rk);
            6:       word = rr_word(op_sltu, rd, rj, rk);
            7:       word = addi_word(rd, rj, r[11:0]);
            8:       word = lu12i_word(rd, r[19:0]);
            default: word = {op_unknown, rk, rj, rd};
        endcase
    endtask

    task automatic random_stream(input int count, input bit gaps);
        logic [31:0] word;
        int          r;
        for (int i = 0; i < count; i++) begin
            random_inst(word);
            issue_inst(word);
            r = $random(seed);
            if (gaps && r[0]) begin
                idle_cycle();
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (expect_q.size() != 0 && n < drain_limit) begin
            @(posedge aclk);
            n++;
        end
        if (expect_q.size() != 0) begin
            $display("timeout: %0d expected trace writes never appeared", expect_q.size());
            $display("TB FAILED");
            $fatal(1, "drain timeout");
        end
    endtask

    // trace is stable around the falling edge
    always @(negedge aclk) begin
        wb_entry_t e;
        if (!reset && debug_wb_rf_we != 4'h0) begin
            if (expect_q.size() == 0) begin
                $display("trace write to r%0d at %0t with no write expected",
                         debug_wb_rf_wnum, $time);
                $display("TB FAILED");
                $fatal(1, "unexpected trace write");
            end else begin
                e = expect_q.pop_front();
                check_value("debug_wb_pc", debug_wb_pc, e.pc);
                check_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(e.wnum));
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, e.wdata);
                check_value("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'hf);
                check_value("write latency", cycle_cnt - e.stamp, wb_latency);
            end
        end
    end

    initial begin
        #(clk_period * watchdog_cycles);
        $display("watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        seed       = 49;
        reset      = 1'b1;
        // a writing word held through reset must never retire
        inst_valid = 1'b1;
        inst_word  = addi_word(5'd1, 5'd0, 12'h7ff);
        model_pc   = reset_pc;
        for (int i = 0; i < nreg; i++) begin
            model_regs[i] = '0;
        end
        repeat (reset_cycles) @(posedge aclk);
        #1;
        reset      = 1'b0;
        inst_valid = 1'b0;
        inst_word  = '0;

        // each instruction alone with signed and unsigned corner values
        issue_alone(lu12i_word(5'd1, 20'h80000));
        issue_alone(addi_word(5'd2, 5'd0, 12'd5));
        issue_alone(addi_word(5'd3, 5'd2, 12'hff4));
        issue_alone(rr_word(op_add_w, 5'd4, 5'd1, 5'd3));
        issue_alone(rr_word(op_sub_w, 5'd5, 5'd2, 5'd3));
        issue_alone(rr_word(op_and, 5'd6, 5'd1, 5'd3));
        issue_alone(rr_word(op_or, 5'd7, 5'd2, 5'd3));
        issue_alone(rr_word(op_xor, 5'd4, 5'd3, 5'd2));
        issue_alone(rr_word(op_slt, 5'd5, 5'd1, 5'd2));
        issue_alone(rr_word(op_sltu, 5'd6, 5'd1, 5'd2));
        issue_alone(rr_word(op_slt, 5'd7, 5'd2, 5'd3));
        issue_alone(rr_word(op_sltu, 5'd7, 5'd2, 5'd3));
        issue_alone({op_unknown, 15'h1234});

        // bypass from execute and result where execute has priority
        issue_inst(addi_word(5'd1, 5'd0, 12'd100));
        issue_inst(addi_word(5'd2, 5'd1, 12'd1));
        issue_inst(rr_word(op_add_w, 5'd3, 5'd1, 5'd2));
        issue_inst(rr_word(op_sub_w, 5'd4, 5'd3, 5'd1));
        issue_inst(addi_word(5'd5, 5'd0, 12'd1));
        issue_inst(addi_word(5'd5, 5'd0, 12'd2));
        issue_inst(rr_word(op_add_w, 5'd6, 5'd5, 5'd5));
        issue_inst(addi_word(5'd0, 5'd1, 12'd9));
        issue_inst(rr_word(op_add_w, 5'd7, 5'd0, 5'd1));
        issue_inst(rr_word(op_or, 5'd0, 5'd7, 5'd6));
        issue_inst(rr_word(op_xor, 5'd2, 5'd0, 5'd6));

        random_stream(200, 1'b0);
        random_stream(100, 1'b1);
        idle_cycle();
        wait_drain();

        $display("TB PASSED");
        $finish;
    end

endmodule
